//--- hdl/fp_bank.sv
// Floating-point pair bank
`timescale 1ns/1ps
`default_nettype none

module fp_bank (
	input  wire logic Clk,
	input  wire logic rst_i,
	fp_wr_if.dst      wr,
	fp_rd_if.rsp      rd
);
	import regfile_geom_pkg::*;

	localparam int PAIR_COUNT = REG_COUNT / 2;

	// even register of each pair, holds the high word
	word_t msw_q [PAIR_COUNT];
	// odd register of each pair
	word_t lsw_q [PAIR_COUNT];

	always_ff @(posedge Clk) begin
		if (rst_i) begin
			for (int i = 0; i < PAIR_COUNT; i++) begin
				msw_q[i] <= '0;
				lsw_q[i] <= '0;
			end
		end else if (wr.en) begin
			msw_q[wr.pair] <= wr.msw; // both halves in one cycle
			lsw_q[wr.pair] <= wr.lsw;
		end
	end

	assign rd.rs_msw = msw_q[rd.rs_pair];
	assign rd.rs_lsw = lsw_q[rd.rs_pair];
	assign rd.rt_msw = msw_q[rd.rt_pair];
	assign rd.rt_lsw = lsw_q[rd.rt_pair];

endmodule

`default_nettype wire

//--- hdl/int_bank.sv
// Integer register bank with HI/LO
`timescale 1ns/1ps
`default_nettype none

module int_bank (
	input  wire logic                       Clk,
	input  wire logic                       rst_i,
	input  wire logic                       int_wr_en_i,
	input  wire regfile_geom_pkg::reg_idx_t int_wr_idx_i,
	input  wire regfile_geom_pkg::word_t    int_wr_data_i,
	input  wire logic                       hilo_wr_en_i,
	input  wire regfile_geom_pkg::dword_t   hilo_wr_data_i,
	output regfile_geom_pkg::word_t         hi_o,
	output regfile_geom_pkg::word_t         lo_o,
	output logic                            fp_flag_o,
	int_rd_if.rsp                           rd
);
	import regfile_geom_pkg::*;
	import regfile_ops_pkg::*;

	word_t regs [1:REG_COUNT-1]; // r0 has no storage
	word_t hi_q;
	word_t lo_q;

	function automatic word_t read_reg(input reg_idx_t idx);
		if (idx == '0)
			return '0;
		return regs[idx];
	endfunction

	always_ff @(posedge Clk) begin
		if (rst_i) begin
			for (int i = 1; i < REG_COUNT; i++)
				regs[i] <= '0;
			hi_q <= '0;
			lo_q <= '0;
		end else begin
			if (int_wr_en_i && int_wr_idx_i != '0)
				regs[int_wr_idx_i] <= int_wr_data_i;
			if (hilo_wr_en_i) begin
				hi_q <= hilo_wr_data_i[2*WORD_W-1:WORD_W];
				lo_q <= hilo_wr_data_i[WORD_W-1:0];
			end
		end
	end

	// read ports see the contents before this edge's write
	always_comb begin
		rd.rs_data = read_reg(rd.rs_idx);
		rd.rt_data = read_reg(rd.rt_idx);
		rd.rd_data = read_reg(rd.rd_idx);
	end

	assign hi_o      = hi_q;
	assign lo_o      = lo_q;
	assign fp_flag_o = regs[FRAME_REG][0]; // live, outside the handshake

endmodule

`default_nettype wire

//--- hdl/read_stage.sv
// Read request and response stage
`timescale 1ns/1ps
`default_nettype none

module read_stage (
	input  wire logic                       Clk,
	input  wire logic                       rst_i,
	input  wire logic                       rd_valid_i,
	input  wire regfile_ops_pkg::rd_mode_t  rd_mode_i,
	input  wire regfile_geom_pkg::reg_idx_t rs_idx_i,
	input  wire regfile_geom_pkg::reg_idx_t rt_idx_i,
	input  wire regfile_geom_pkg::reg_idx_t rd_idx_i,
	input  wire logic                       rsp_ready_i,
	input  wire regfile_geom_pkg::word_t    hi_i,
	input  wire regfile_geom_pkg::word_t    lo_i,
	output logic                            rd_ready_o,
	output logic                            rsp_valid_o,
	output regfile_geom_pkg::word_t         rs_data_o,
	output regfile_geom_pkg::word_t         rs_msw_o,
	output regfile_geom_pkg::word_t         rt_data_o,
	output regfile_geom_pkg::word_t         rt_msw_o,
	output regfile_geom_pkg::word_t         rd_data_o,
	output regfile_geom_pkg::word_t         hi_o,
	output regfile_geom_pkg::word_t         lo_o,
	int_rd_if.req                           irf,
	fp_rd_if.req                            frf
);
	import regfile_geom_pkg::*;
	import regfile_ops_pkg::*;

	logic  rsp_valid_q;
	logic  accept;
	word_t fp_rs_msw;
	word_t fp_rs_lsw;
	word_t fp_rt_msw;
	word_t fp_rt_lsw;
	word_t nxt_rs;
	word_t nxt_rs_msw;
	word_t nxt_rt;
	word_t nxt_rt_msw;
	word_t rs_q;
	word_t rs_msw_q;
	word_t rt_q;
	word_t rt_msw_q;
	word_t rd_q;
	word_t hi_q;
	word_t lo_q;

	assign rd_ready_o = ~rsp_valid_q | rsp_ready_i; // empty or draining now
	assign accept     = rd_valid_i & rd_ready_o;

	// bank lookups straight from the request
	assign irf.rs_idx  = rs_idx_i;
	assign irf.rt_idx  = rt_idx_i;
	assign irf.rd_idx  = rd_idx_i;
	assign frf.rs_pair = rs_idx_i[$bits(reg_idx_t)-1:1];
	assign frf.rt_pair = rt_idx_i[$bits(reg_idx_t)-1:1];

	// odd index is not a double, reads as zero
	assign fp_rs_msw = rs_idx_i[0] ? '0 : frf.rs_msw;
	assign fp_rs_lsw = rs_idx_i[0] ? '0 : frf.rs_lsw;
	assign fp_rt_msw = rt_idx_i[0] ? '0 : frf.rt_msw;
	assign fp_rt_lsw = rt_idx_i[0] ? '0 : frf.rt_lsw;

	always_comb begin
		nxt_rs     = irf.rs_data;
		nxt_rs_msw = '0;
		nxt_rt     = irf.rt_data;
		nxt_rt_msw = '0;
		case (rd_mode_i)
			RD_INT: ;
			RD_FP: begin
				nxt_rs     = fp_rs_lsw;
				nxt_rs_msw = fp_rs_msw;
				nxt_rt     = fp_rt_lsw;
				nxt_rt_msw = fp_rt_msw;
			end
			RD_STORE_BYTE: nxt_rt = {{(WORD_W-BYTE_W){1'b0}}, irf.rt_data[BYTE_W-1:0]};
			RD_STORE_FP: begin
				nxt_rt     = fp_rt_lsw; // base address stays integer rs
				nxt_rt_msw = fp_rt_msw;
			end
			default: ;
		endcase
	end

	always_ff @(posedge Clk) begin
		if (rst_i)
			rsp_valid_q <= 1'b0;
		else if (accept)
			rsp_valid_q <= 1'b1;
		else if (rsp_ready_i)
			rsp_valid_q <= 1'b0;
	end

	// payload loads only on accept, so it holds under back-pressure
	always_ff @(posedge Clk) begin
		if (accept) begin
			rs_q     <= nxt_rs;
			rs_msw_q <= nxt_rs_msw;
			rt_q     <= nxt_rt;
			rt_msw_q <= nxt_rt_msw;
			rd_q     <= irf.rd_data;
			hi_q     <= hi_i;
			lo_q     <= lo_i;
		end
	end

	assign rsp_valid_o = rsp_valid_q;
	assign rs_data_o   = rs_q;
	assign rs_msw_o    = rs_msw_q;
	assign rt_data_o   = rt_q;
	assign rt_msw_o    = rt_msw_q;
	assign rd_data_o   = rd_q;
	assign hi_o        = hi_q;
	assign lo_o        = lo_q;

endmodule

`default_nettype wire

//--- hdl/regfile_geom_pkg.sv
// Register file geometry
`default_nettype none

package regfile_geom_pkg;

	localparam int REG_COUNT = 32; // registers per bank
	localparam int WORD_W    = 32;
	localparam int BYTE_W    = 8;

	// 5-bit register number as encoded in the instruction
	typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;

	// even/odd pair number, drops bit 0 of the register number
	typedef logic [$clog2(REG_COUNT)-2:0] pair_idx_t;

	typedef logic [WORD_W-1:0] word_t;

	// upper half is the more significant word, stored at the even index
	typedef logic [2*WORD_W-1:0] dword_t;

endpackage

`default_nettype wire

//--- hdl/regfile_if.sv
// Register file internal buses
`timescale 1ns/1ps
`default_nettype none

// pair write from the decoder into the floating-point bank
interface fp_wr_if;
	logic                        en;
	regfile_geom_pkg::pair_idx_t pair;
	regfile_geom_pkg::word_t     msw; // goes to the even register
	regfile_geom_pkg::word_t     lsw; // goes to the odd register

	modport src (output en, output pair, output msw, output lsw);
	modport dst (input en, input pair, input msw, input lsw);
endinterface

// three integer read ports
interface int_rd_if;
	regfile_geom_pkg::reg_idx_t rs_idx;
	regfile_geom_pkg::reg_idx_t rt_idx;
	regfile_geom_pkg::reg_idx_t rd_idx;
	regfile_geom_pkg::word_t    rs_data;
	regfile_geom_pkg::word_t    rt_data;
	regfile_geom_pkg::word_t    rd_data;

	modport req (output rs_idx, output rt_idx, output rd_idx,
		input rs_data, input rt_data, input rd_data);
	modport rsp (input rs_idx, input rt_idx, input rd_idx,
		output rs_data, output rt_data, output rd_data);
endinterface

// two floating-point pair read ports
interface fp_rd_if;
	regfile_geom_pkg::pair_idx_t rs_pair;
	regfile_geom_pkg::pair_idx_t rt_pair;
	regfile_geom_pkg::word_t     rs_msw;
	regfile_geom_pkg::word_t     rs_lsw;
	regfile_geom_pkg::word_t     rt_msw;
	regfile_geom_pkg::word_t     rt_lsw;

	modport req (output rs_pair, output rt_pair,
		input rs_msw, input rs_lsw, input rt_msw, input rt_lsw);
	modport rsp (input rs_pair, input rt_pair,
		output rs_msw, output rs_lsw, output rt_msw, output rt_lsw);
endinterface

`default_nettype wire

//--- hdl/regfile_ops_pkg.sv
// Register file operation codes
`default_nettype none

package regfile_ops_pkg;

	// write operation, selects target bank and data shaping
	typedef enum logic [2:0] {
		WR_WORD      = 3'd0, // full integer word
		WR_BYTE      = 3'd1, // load byte, zero extended
		WR_LINK      = 3'd2, // return address into r31
		WR_FRAME     = 3'd3, // frame pointer into r30
		WR_FP_DOUBLE = 3'd4, // 64-bit double into a pair
		WR_FP_WORD   = 3'd5, // single word, even half cleared
		WR_HILO      = 3'd6  // multiply/divide result
	} wr_op_t;

	// read mode, selects which banks feed the response
	typedef enum logic [1:0] {
		RD_INT        = 2'd0,
		RD_FP         = 2'd1,
		RD_STORE_BYTE = 2'd2,
		RD_STORE_FP   = 2'd3
	} rd_mode_t;

	localparam regfile_geom_pkg::reg_idx_t LINK_REG  = 5'd31; // ra
	localparam regfile_geom_pkg::reg_idx_t FRAME_REG = 5'd30; // fp, bit 0 is the fp flag

endpackage

`default_nettype wire

//--- hdl/regfile_top.sv
// MIPS decode-stage register file
`timescale 1ns/1ps
`default_nettype none

module regfile_top (
	input  wire logic                       Clk,
	input  wire logic                       rst_i,
	input  wire logic                       wr_valid_i,
	input  wire regfile_ops_pkg::wr_op_t    wr_op_i,
	input  wire regfile_geom_pkg::reg_idx_t wr_idx_i,
	input  wire regfile_geom_pkg::word_t    wr_data_i,
	input  wire regfile_geom_pkg::dword_t   wr_data64_i,
	input  wire logic                       rd_valid_i,
	input  wire regfile_ops_pkg::rd_mode_t  rd_mode_i,
	input  wire regfile_geom_pkg::reg_idx_t rs_idx_i,
	input  wire regfile_geom_pkg::reg_idx_t rt_idx_i,
	input  wire regfile_geom_pkg::reg_idx_t rd_idx_i,
	input  wire logic                       rsp_ready_i,
	output logic                            rd_ready_o,
	output logic                            rsp_valid_o,
	output regfile_geom_pkg::word_t         rs_data_o,
	output regfile_geom_pkg::word_t         rs_msw_o,
	output regfile_geom_pkg::word_t         rt_data_o,
	output regfile_geom_pkg::word_t         rt_msw_o,
	output regfile_geom_pkg::word_t         rd_data_o,
	output regfile_geom_pkg::word_t         hi_o,
	output regfile_geom_pkg::word_t         lo_o,
	output logic                            fp_flag_o
);
	import regfile_geom_pkg::*;

	logic     int_wr_en;
	reg_idx_t int_wr_idx;
	word_t    int_wr_data;
	logic     hilo_wr_en;
	dword_t   hilo_wr_data;
	word_t    bank_hi; // live HI/LO, captured per response
	word_t    bank_lo;

	fp_wr_if  fp_wr_bus ();
	int_rd_if int_rd_bus ();
	fp_rd_if  fp_rd_bus ();

	write_decoder u_write_decoder (
		.wr_valid_i     (wr_valid_i),
		.wr_op_i        (wr_op_i),
		.wr_idx_i       (wr_idx_i),
		.wr_data_i      (wr_data_i),
		.wr_data64_i    (wr_data64_i),
		.int_wr_en_o    (int_wr_en),
		.int_wr_idx_o   (int_wr_idx),
		.int_wr_data_o  (int_wr_data),
		.hilo_wr_en_o   (hilo_wr_en),
		.hilo_wr_data_o (hilo_wr_data),
		.fp_wr          (fp_wr_bus)
	);

	int_bank u_int_bank (
		.Clk            (Clk),
		.rst_i          (rst_i),
		.int_wr_en_i    (int_wr_en),
		.int_wr_idx_i   (int_wr_idx),
		.int_wr_data_i  (int_wr_data),
		.hilo_wr_en_i   (hilo_wr_en),
		.hilo_wr_data_i (hilo_wr_data),
		.hi_o           (bank_hi),
		.lo_o           (bank_lo),
		.fp_flag_o      (fp_flag_o),
		.rd             (int_rd_bus)
	);

	fp_bank u_fp_bank (
		.Clk   (Clk),
		.rst_i (rst_i),
		.wr    (fp_wr_bus),
		.rd    (fp_rd_bus)
	);

	read_stage u_read_stage (
		.Clk         (Clk),
		.rst_i       (rst_i),
		.rd_valid_i  (rd_valid_i),
		.rd_mode_i   (rd_mode_i),
		.rs_idx_i    (rs_idx_i),
		.rt_idx_i    (rt_idx_i),
		.rd_idx_i    (rd_idx_i),
		.rsp_ready_i (rsp_ready_i),
		.hi_i        (bank_hi),
		.lo_i        (bank_lo),
		.rd_ready_o  (rd_ready_o),
		.rsp_valid_o (rsp_valid_o),
		.rs_data_o   (rs_data_o),
		.rs_msw_o    (rs_msw_o),
		.rt_data_o   (rt_data_o),
		.rt_msw_o    (rt_msw_o),
		.rd_data_o   (rd_data_o),
		.hi_o        (hi_o),
		.lo_o        (lo_o),
		.irf         (int_rd_bus),
		.frf         (fp_rd_bus)
	);

endmodule

`default_nettype wire

//--- hdl/write_decoder.sv
// Write request decoder
`timescale 1ns/1ps
`default_nettype none

module write_decoder (
	input  wire logic                       wr_valid_i,
	input  wire regfile_ops_pkg::wr_op_t    wr_op_i,
	input  wire regfile_geom_pkg::reg_idx_t wr_idx_i,
	input  wire regfile_geom_pkg::word_t    wr_data_i,
	input  wire regfile_geom_pkg::dword_t   wr_data64_i,
	output logic                            int_wr_en_o,
	output regfile_geom_pkg::reg_idx_t      int_wr_idx_o,
	output regfile_geom_pkg::word_t         int_wr_data_o,
	output logic                            hilo_wr_en_o,
	output regfile_geom_pkg::dword_t        hilo_wr_data_o,
	fp_wr_if.src                            fp_wr
);
	import regfile_geom_pkg::*;
	import regfile_ops_pkg::*;

	logic     int_sel; // op targets the integer bank
	logic     fp_sel;
	logic     hilo_sel;
	reg_idx_t int_idx;
	word_t    int_data;
	word_t    fp_msw;
	word_t    fp_lsw;

	always_comb begin
		int_sel  = 1'b0;
		fp_sel   = 1'b0;
		hilo_sel = 1'b0;
		int_idx  = wr_idx_i;
		int_data = wr_data_i;
		fp_msw   = wr_data64_i[2*WORD_W-1:WORD_W]; // big end at even index
		fp_lsw   = wr_data64_i[WORD_W-1:0];
		case (wr_op_i)
			WR_WORD: int_sel = 1'b1;
			WR_BYTE: begin
				int_sel  = 1'b1;
				int_data = {{(WORD_W-BYTE_W){1'b0}}, wr_data_i[BYTE_W-1:0]};
			end
			WR_LINK: begin
				int_sel = 1'b1;
				int_idx = LINK_REG; // index from the op, not the request
			end
			WR_FRAME: begin
				int_sel = 1'b1;
				int_idx = FRAME_REG;
			end
			WR_FP_DOUBLE: fp_sel = 1'b1;
			WR_FP_WORD: begin
				fp_sel = 1'b1;
				fp_msw = '0; // even half cleared
				fp_lsw = wr_data_i;
			end
			WR_HILO: hilo_sel = 1'b1;
			default: ;
		endcase
	end

	// r0 stays zero, odd pair index is not a valid double
	assign int_wr_en_o   = wr_valid_i & int_sel & (int_idx != '0);
	assign int_wr_idx_o  = int_idx;
	assign int_wr_data_o = int_data;

	assign hilo_wr_en_o   = wr_valid_i & hilo_sel;
	assign hilo_wr_data_o = wr_data64_i;

	assign fp_wr.en   = wr_valid_i & fp_sel & ~wr_idx_i[0];
	assign fp_wr.pair = wr_idx_i[$bits(reg_idx_t)-1:1];
	assign fp_wr.msw  = fp_msw;
	assign fp_wr.lsw  = fp_lsw;

endmodule

`default_nettype wire

//--- regfile.f
hdl/regfile_geom_pkg.sv
hdl/regfile_ops_pkg.sv
hdl/regfile_if.sv
hdl/write_decoder.sv
hdl/int_bank.sv
hdl/fp_bank.sv
hdl/read_stage.sv
hdl/regfile_top.sv
tests/regfile_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the register file testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log
rm -rf obj_dir

verilator --binary --timing --assert -j 0 --top-module regfile_tb -f regfile.f

# a failing run exits non-zero, the log search gives the verdict
./obj_dir/Vregfile_tb > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
	echo "simulation reported a failure"
	exit 1
fi
echo "simulation finished cleanly"

//--- tests/regfile_tb.sv
// Register file testbench
`timescale 1ns/1ps
`default_nettype none

module regfile_tb;
	import regfile_geom_pkg::*;
	import regfile_ops_pkg::*;

	localparam int NSTEP   = 15;
	localparam int TIMEOUT = 16; // cycles allowed per wait

	typedef struct packed {
		logic     wr_valid;
		wr_op_t   wr_op;
		reg_idx_t wr_idx;
		word_t    wr_data;
		dword_t   wr_data64;
		logic     rd_same; // read request raised at the write edge
		rd_mode_t rd_mode;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		logic     flag; // expected fp_flag_o
	} step_t;

	// wr_valid, op, idx, data, data64, same edge, mode, rs, rt, rd, flag
	localparam step_t STEPS [NSTEP] = '{
		'{1'b0, WR_WORD, 5'd0, 32'h0, 64'h0, 1'b0, RD_INT, 5'd8, 5'd19, 5'd31, 1'b0},
		'{1'b1, WR_WORD, 5'd8, 32'h0A12, 64'h0, 1'b0, RD_INT, 5'd8, 5'd19, 5'd8, 1'b0},
		'{1'b1, WR_WORD, 5'd19, 32'hFFFF, 64'h0, 1'b0, RD_INT, 5'd19, 5'd8, 5'd19, 1'b0},
		'{1'b1, WR_WORD, 5'd0, 32'h1234, 64'h0, 1'b0, RD_INT, 5'd0, 5'd0, 5'd0, 1'b0},
		'{1'b1, WR_BYTE, 5'd17, 32'h443322, 64'h0, 1'b0, RD_INT, 5'd17, 5'd0, 5'd17, 1'b0},
		'{1'b1, WR_LINK, 5'd5, 32'h400010, 64'h0, 1'b0, RD_INT, 5'd31, 5'd5, 5'd31, 1'b0},
		'{1'b1, WR_FRAME, 5'd0, 32'h1, 64'h0, 1'b0, RD_INT, 5'd30, 5'd0, 5'd30, 1'b1},
		'{1'b1, WR_FP_DOUBLE, 5'd0, 32'h0, 64'hFF_FFFF_FFFF, 1'b0, RD_FP,
			5'd0, 5'd6, 5'd8, 1'b1},
		'{1'b1, WR_FP_WORD, 5'd6, 32'hEE, 64'h1111_2222_3333_4444, 1'b0, RD_FP,
			5'd6, 5'd0, 5'd19, 1'b1},
		'{1'b1, WR_FP_DOUBLE, 5'd7, 32'h0, 64'hDEAD_BEEF_0BAD_F00D, 1'b0, RD_FP,
			5'd6, 5'd7, 5'd0, 1'b1},
		'{1'b1, WR_HILO, 5'd0, 32'h0, 64'hFFFF_FFFF_0000_0000, 1'b0, RD_INT,
			5'd8, 5'd19, 5'd30, 1'b1},
		'{1'b0, WR_WORD, 5'd0, 32'h0, 64'h0, 1'b0, RD_STORE_BYTE, 5'd8, 5'd19, 5'd0, 1'b1},
		'{1'b0, WR_WORD, 5'd0, 32'h0, 64'h0, 1'b0, RD_STORE_FP, 5'd8, 5'd0, 5'd0, 1'b1},
		'{1'b1, WR_WORD, 5'd8, 32'hCAFE, 64'h0, 1'b1, RD_INT, 5'd8, 5'd8, 5'd8, 1'b1},
		'{1'b0, WR_WORD, 5'd0, 32'h0, 64'h0, 1'b0, RD_INT, 5'd8, 5'd0, 5'd8, 1'b1}
	};

	// rs, rs_msw, rt, rt_msw, rd, hi, lo
	localparam word_t EXP [NSTEP][7] = '{
		'{'0, '0, '0, '0, '0, '0, '0},
		'{32'h0A12, '0, '0, '0, 32'h0A12, '0, '0},
		'{32'hFFFF, '0, 32'h0A12, '0, 32'hFFFF, '0, '0},
		'{'0, '0, '0, '0, '0, '0, '0}, // r0 ignores writes
		'{32'h22, '0, '0, '0, 32'h22, '0, '0},
		'{32'h400010, '0, '0, '0, 32'h400010, '0, '0},
		'{32'h1, '0, '0, '0, 32'h1, '0, '0},
		'{32'hFFFFFFFF, 32'hFF, '0, '0, 32'h0A12, '0, '0},
		'{32'hEE, '0, 32'hFFFFFFFF, 32'hFF, 32'hFFFF, '0, '0},
		'{32'hEE, '0, '0, '0, '0, '0, '0}, // odd write dropped and odd read zero
		'{32'h0A12, '0, 32'hFFFF, '0, 32'h1, 32'hFFFFFFFF, '0},
		'{32'h0A12, '0, 32'hFF, '0, '0, 32'hFFFFFFFF, '0},
		'{32'h0A12, '0, 32'hFFFFFFFF, 32'hFF, '0, 32'hFFFFFFFF, '0},
		'{32'h0A12, '0, 32'h0A12, '0, 32'h0A12, 32'hFFFFFFFF, '0}, // old value
		'{32'hCAFE, '0, '0, '0, 32'hCAFE, 32'hFFFFFFFF, '0}
	};

	string out_names [7] = '{"rs_data_o", "rs_msw_o", "rt_data_o", "rt_msw_o",
		"rd_data_o", "hi_o", "lo_o"};

	logic     Clk;
	logic     rst_i       = 1'b1;
	logic     wr_valid_i  = 1'b0;
	wr_op_t   wr_op_i     = WR_WORD;
	reg_idx_t wr_idx_i    = '0;
	word_t    wr_data_i   = '0;
	dword_t   wr_data64_i = '0;
	logic     rd_valid_i  = 1'b0;
	rd_mode_t rd_mode_i   = RD_INT;
	reg_idx_t rs_idx_i    = '0;
	reg_idx_t rt_idx_i    = '0;
	reg_idx_t rd_idx_i    = '0;
	logic     rsp_ready_i = 1'b0;
	logic     rd_ready_o;
	logic     rsp_valid_o;
	logic     fp_flag_o;
	word_t    rs_data_o;
	word_t    rs_msw_o;
	word_t    rt_data_o;
	word_t    rt_msw_o;
	word_t    rd_data_o;
	word_t    hi_o;
	word_t    lo_o;

	regfile_top dut_i (.*);

	initial begin
		Clk = 1'b0;
		forever #4 Clk = ~Clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	// polls at falling edges and counts the extra cycles in n
	task automatic wait_handshake(input bit for_rsp, output int n);
		string what;
		if (for_rsp)
			what = "rsp_valid_o";
		else
			what = "rd_ready_o";
		n = 0;
		@(negedge Clk);
		while (!(for_rsp ? rsp_valid_o : rd_ready_o)) begin
			n++;
			if (n > TIMEOUT)
				fail_run($sformatf("timeout waiting for %s", what));
			@(negedge Clk);
		end
	endtask

	task automatic check_rsp(input int s);
		word_t got [7];
		got = '{rs_data_o, rs_msw_o, rt_data_o, rt_msw_o, rd_data_o, hi_o, lo_o};
		for (int k = 0; k < 7; k++)
			assert (got[k] == EXP[s][k]) else
				fail_run($sformatf("ERROR step %0d: %s = %h, expected %h",
					s, out_names[k], got[k], EXP[s][k]));
		assert (fp_flag_o == STEPS[s].flag) else
			fail_run($sformatf("ERROR step %0d: fp_flag_o = %h, expected %h",
				s, fp_flag_o, STEPS[s].flag));
	endtask

	task automatic run_step(input int s);
		int          n;
		int unsigned hold;
		@(posedge Clk);
		wr_valid_i  <= STEPS[s].wr_valid;
		wr_op_i     <= STEPS[s].wr_op;
		wr_idx_i    <= STEPS[s].wr_idx;
		wr_data_i   <= STEPS[s].wr_data;
		wr_data64_i <= STEPS[s].wr_data64;
		rd_mode_i   <= STEPS[s].rd_mode;
		rs_idx_i    <= STEPS[s].rs;
		rt_idx_i    <= STEPS[s].rt;
		rd_idx_i    <= STEPS[s].rd;
		rd_valid_i  <= STEPS[s].rd_same;
		if (!STEPS[s].rd_same) begin
			@(posedge Clk); // write lands first
			wr_valid_i <= 1'b0;
			rd_valid_i <= 1'b1;
		end
		wait_handshake(1'b0, n);
		@(posedge Clk); // accepting edge
		wr_valid_i <= 1'b0;
		// next request stays pending and must be refused
		rs_idx_i   <= ~STEPS[s].rs;
		rt_idx_i   <= ~STEPS[s].rt;
		rd_idx_i   <= ~STEPS[s].rd;
		wait_handshake(1'b1, n);
		assert (n == 0) else
			fail_run($sformatf("step %0d: response arrived %0d cycles late", s, n));
		check_rsp(s);
		hold = $urandom % 4;
		repeat (hold) begin
			@(negedge Clk);
			assert (rsp_valid_o && !rd_ready_o) else
				fail_run($sformatf(
					"ERROR step %0d: rsp_valid_o = %h, rd_ready_o = %h, expected 1 and 0",
					s, rsp_valid_o, rd_ready_o));
			check_rsp(s);
		end
		@(posedge Clk);
		rd_valid_i  <= 1'b0;
		rsp_ready_i <= 1'b1;
		@(negedge Clk);
		check_rsp(s); // held across the last refused edge
		@(posedge Clk); // response consumed
		rsp_ready_i <= 1'b0;
		@(negedge Clk);
		assert (!rsp_valid_o) else
			fail_run($sformatf("ERROR step %0d: rsp_valid_o = %h after consumption, expected 0",
				s, rsp_valid_o));
	endtask

	initial begin
		void'($urandom(32'h499d2e2c));
		repeat (8) @(posedge Clk);
		rst_i <= 1'b0;
		@(negedge Clk);
		assert (!rsp_valid_o && rd_ready_o && !fp_flag_o) else
			fail_run($sformatf(
				"ERROR after reset: rsp_valid_o = %h, rd_ready_o = %h, fp_flag_o = %h",
				rsp_valid_o, rd_ready_o, fp_flag_o));
		for (int s = 0; s < NSTEP; s++)
			run_step(s);
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire
